/* regfile_pkg.sv */
package regfile_pkg;

   // Entries per file and index width
   localparam int num_regs = 8;
   localparam int reg_id_w = 3;

   // Payload widths
   localparam int gpr_w = 32;
   localparam int seg_w = 16;
   localparam int mm_w  = 64;

   // GPR port counts
   localparam int num_gpr_rd = 4;
   localparam int num_gpr_wr = 3;

   // One lane per byte of a GPR
   localparam int num_lanes = gpr_w / 8;

   typedef logic [reg_id_w-1:0]  reg_id_t;
   typedef logic [gpr_w-1:0]     gpr_data_t;
   typedef logic [seg_w-1:0]     seg_data_t;
   typedef logic [mm_w-1:0]      mm_data_t;
   typedef logic [num_lanes-1:0] lane_en_t;

   // Operand size of a GPR access, encoded as in the core
   typedef enum logic [1:0] {
      size_lo8 = 2'd0,
      size_hi8 = 2'd1,
      size_16  = 2'd2,
      size_32  = 2'd3
   } op_size_e;

   // One GPR write port
   typedef struct packed {
      logic      we;
      reg_id_t   id;
      op_size_e  size;
      gpr_data_t data;
   } gpr_wr_t;

   // One GPR read port
   typedef struct packed {
      reg_id_t  id;
      op_size_e size;
   } gpr_rd_t;

endpackage

/* gpr_write_arbiter.sv */
module gpr_write_arbiter (
   input  regfile_pkg::gpr_wr_t   wr      [regfile_pkg::num_gpr_wr],
   output regfile_pkg::lane_en_t  lane_we [regfile_pkg::num_regs],
   output regfile_pkg::gpr_data_t wr_word [regfile_pkg::num_regs]
);

   // Lanes touched by each port, already qualified by its strobe
   regfile_pkg::lane_en_t port_lanes [regfile_pkg::num_gpr_wr];

   always_comb begin
      for (int p = 0; p < regfile_pkg::num_gpr_wr; p++) begin
         case (wr[p].size)
            regfile_pkg::size_lo8: begin
               port_lanes[p] = regfile_pkg::lane_en_t'(4'b0001);
            end
            regfile_pkg::size_hi8: begin
               port_lanes[p] = regfile_pkg::lane_en_t'(4'b0010);
            end
            regfile_pkg::size_16: begin
               port_lanes[p] = regfile_pkg::lane_en_t'(4'b0011);
            end
            default: begin
               port_lanes[p] = regfile_pkg::lane_en_t'(4'b1111);
            end
         endcase
         if (!wr[p].we) begin
            port_lanes[p] = '0;
         end
      end
   end

   // Per register and byte lane, walk the ports from the highest index down
   // so the lowest-numbered active port is the one left standing
   always_comb begin
      for (int r = 0; r < regfile_pkg::num_regs; r++) begin
         lane_we[r] = '0;
         wr_word[r] = '0;
         for (int l = 0; l < regfile_pkg::num_lanes; l++) begin
            for (int p = regfile_pkg::num_gpr_wr - 1; p >= 0; p--) begin
               if (port_lanes[p][l] && (wr[p].id == regfile_pkg::reg_id_t'(r))) begin
                  lane_we[r][l]        = 1'b1;
                  wr_word[r][l*8 +: 8] = wr[p].data[l*8 +: 8];
               end
            end
         end
      end
   end

endmodule

/* gpr_read_port.sv */
module gpr_read_port (
   input  regfile_pkg::gpr_data_t regs [regfile_pkg::num_regs],
   input  regfile_pkg::gpr_rd_t   rd,
   output regfile_pkg::gpr_data_t dout
);

   regfile_pkg::gpr_data_t word;

   assign word = regs[rd.id];

   // Shape to operand size, zero above the operand
   always_comb begin
      case (rd.size)
         regfile_pkg::size_lo8: begin
            dout = {24'h0, word[7:0]};
         end
         regfile_pkg::size_hi8: begin
            // AH/CH/DH/BH come back in the low byte
            dout = {24'h0, word[15:8]};
         end
         regfile_pkg::size_16: begin
            dout = {16'h0, word[15:0]};
         end
         default: begin
            dout = word;
         end
      endcase
   end

endmodule

/* gpr_array.sv */
module gpr_array (
   input  logic                   clk,
   input  logic                   rst_n,
   input  regfile_pkg::lane_en_t  lane_we [regfile_pkg::num_regs],
   input  regfile_pkg::gpr_data_t wr_word [regfile_pkg::num_regs],
   input  regfile_pkg::gpr_rd_t   rd      [regfile_pkg::num_gpr_rd],
   output regfile_pkg::gpr_data_t dout    [regfile_pkg::num_gpr_rd]
);

   regfile_pkg::gpr_data_t regs [regfile_pkg::num_regs];

   // Byte-lane writes, untouched lanes hold
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int r = 0; r < regfile_pkg::num_regs; r++) begin
            regs[r] <= '0;
         end
      end else begin
         for (int r = 0; r < regfile_pkg::num_regs; r++) begin
            for (int l = 0; l < regfile_pkg::num_lanes; l++) begin
               if (lane_we[r][l]) begin
                  regs[r][l*8 +: 8] <= wr_word[r][l*8 +: 8];
               end
            end
         end
      end
   end

   // Four independent sized read ports
   for (genvar i = 0; i < regfile_pkg::num_gpr_rd; i++) begin : g_rd
      gpr_read_port rd_port (
         .regs (regs),
         .rd   (rd[i]),
         .dout (dout[i])
      );
   end

endmodule

/* dual_read_regfile.sv */
module dual_read_regfile #(
   parameter type data_t = regfile_pkg::seg_data_t
) (
   input  logic                 clk,
   input  logic                 rst_n,
   input  data_t                din,
   input  regfile_pkg::reg_id_t wr_id,
   input  logic                 we,
   input  regfile_pkg::reg_id_t rd_id1,
   input  regfile_pkg::reg_id_t rd_id2,
   output data_t                dout1,
   output data_t                dout2
);

   data_t mem [regfile_pkg::num_regs];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int r = 0; r < regfile_pkg::num_regs; r++) begin
            mem[r] <= '0;
         end
      end else if (we) begin
         mem[wr_id] <= din;
      end
   end

   // No bypass, a same-cycle write shows up next cycle
   assign dout1 = mem[rd_id1];
   assign dout2 = mem[rd_id2];

endmodule

/* arch_state_regs.sv */
module arch_state_regs (
   input  logic                   clk,
   input  logic                   rst_n,
   input  regfile_pkg::seg_data_t cs_din,
   input  regfile_pkg::gpr_data_t eip_din,
   input  regfile_pkg::gpr_data_t eflags_din,
   input  logic                   ld_cs,
   input  logic                   ld_eip,
   input  logic                   ld_eflags,
   output regfile_pkg::seg_data_t cs_dout,
   output regfile_pkg::gpr_data_t eip_dout,
   output regfile_pkg::gpr_data_t eflags_dout
);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cs_dout     <= '0;
         eip_dout    <= '0;
         eflags_dout <= '0;
      end else begin
         if (ld_cs) begin
            cs_dout <= cs_din;
         end
         if (ld_eip) begin
            eip_dout <= eip_din;
         end
         if (ld_eflags) begin
            eflags_dout <= eflags_din;
         end
      end
   end

endmodule

/* register_file.sv */
module register_file (
   input  logic                   clk,
   input  logic                   rst_n,
   // GPR ports
   input  regfile_pkg::gpr_wr_t   gpr_wr   [regfile_pkg::num_gpr_wr],
   input  regfile_pkg::gpr_rd_t   gpr_rd   [regfile_pkg::num_gpr_rd],
   output regfile_pkg::gpr_data_t gpr_dout [regfile_pkg::num_gpr_rd],
   // Segment registers
   input  regfile_pkg::reg_id_t   seg_wr_id,
   input  logic                   seg_we,
   input  regfile_pkg::seg_data_t seg_din,
   input  regfile_pkg::reg_id_t   seg_rd_id1,
   input  regfile_pkg::reg_id_t   seg_rd_id2,
   output regfile_pkg::seg_data_t seg_dout1,
   output regfile_pkg::seg_data_t seg_dout2,
   // MMX registers
   input  regfile_pkg::reg_id_t   mm_wr_id,
   input  logic                   mm_we,
   input  regfile_pkg::mm_data_t  mm_din,
   input  regfile_pkg::reg_id_t   mm_rd_id1,
   input  regfile_pkg::reg_id_t   mm_rd_id2,
   output regfile_pkg::mm_data_t  mm_dout1,
   output regfile_pkg::mm_data_t  mm_dout2,
   // CS, EIP, EFLAGS
   input  regfile_pkg::seg_data_t cs_din,
   input  regfile_pkg::gpr_data_t eip_din,
   input  regfile_pkg::gpr_data_t eflags_din,
   input  logic                   ld_cs,
   input  logic                   ld_eip,
   input  logic                   ld_eflags,
   output regfile_pkg::seg_data_t cs_dout,
   output regfile_pkg::gpr_data_t eip_dout,
   output regfile_pkg::gpr_data_t eflags_dout
);

   regfile_pkg::lane_en_t  lane_we [regfile_pkg::num_regs];
   regfile_pkg::gpr_data_t wr_word [regfile_pkg::num_regs];

   gpr_write_arbiter wr_arb (
      .wr      (gpr_wr),
      .lane_we (lane_we),
      .wr_word (wr_word)
   );

   gpr_array gpr (
      .clk     (clk),
      .rst_n   (rst_n),
      .lane_we (lane_we),
      .wr_word (wr_word),
      .rd      (gpr_rd),
      .dout    (gpr_dout)
   );

   dual_read_regfile #(.data_t(regfile_pkg::seg_data_t)) seg_file (
      .clk    (clk),
      .rst_n  (rst_n),
      .din    (seg_din),
      .wr_id  (seg_wr_id),
      .we     (seg_we),
      .rd_id1 (seg_rd_id1),
      .rd_id2 (seg_rd_id2),
      .dout1  (seg_dout1),
      .dout2  (seg_dout2)
   );

   dual_read_regfile #(.data_t(regfile_pkg::mm_data_t)) mm_file (
      .clk    (clk),
      .rst_n  (rst_n),
      .din    (mm_din),
      .wr_id  (mm_wr_id),
      .we     (mm_we),
      .rd_id1 (mm_rd_id1),
      .rd_id2 (mm_rd_id2),
      .dout1  (mm_dout1),
      .dout2  (mm_dout2)
   );

   arch_state_regs arch_regs (
      .clk         (clk),
      .rst_n       (rst_n),
      .cs_din      (cs_din),
      .eip_din     (eip_din),
      .eflags_din  (eflags_din),
      .ld_cs       (ld_cs),
      .ld_eip      (ld_eip),
      .ld_eflags   (ld_eflags),
      .cs_dout     (cs_dout),
      .eip_dout    (eip_dout),
      .eflags_dout (eflags_dout)
   );

endmodule

/* register_file_tb.sv */
module register_file_tb;
   timeunit 1ns;
   timeprecision 1ps;

   // About 1000 cycles of tests in all
   localparam int max_cycles  = 1500;
   localparam int rand_cycles = 300;

   logic                   clk;
   logic                   rst_n;
   regfile_pkg::gpr_wr_t   gpr_wr   [regfile_pkg::num_gpr_wr];
   regfile_pkg::gpr_rd_t   gpr_rd   [regfile_pkg::num_gpr_rd];
   regfile_pkg::gpr_data_t gpr_dout [regfile_pkg::num_gpr_rd];
   regfile_pkg::reg_id_t   seg_wr_id, seg_rd_id1, seg_rd_id2;
   regfile_pkg::reg_id_t   mm_wr_id, mm_rd_id1, mm_rd_id2;
   logic                   seg_we, mm_we, ld_cs, ld_eip, ld_eflags;
   regfile_pkg::seg_data_t seg_din, seg_dout1, seg_dout2, cs_din, cs_dout;
   regfile_pkg::mm_data_t  mm_din, mm_dout1, mm_dout2;
   regfile_pkg::gpr_data_t eip_din, eflags_din, eip_dout, eflags_dout;

   // Reference state
   regfile_pkg::gpr_data_t model_gpr [regfile_pkg::num_regs];
   regfile_pkg::seg_data_t model_seg [regfile_pkg::num_regs];
   regfile_pkg::mm_data_t  model_mm  [regfile_pkg::num_regs];
   regfile_pkg::seg_data_t model_cs;
   regfile_pkg::gpr_data_t model_eip, model_eflags;

   string test_name = "reset";
   int    seed;
   int    cycles = 0;

   register_file register_file_i (.*);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   function automatic regfile_pkg::lane_en_t size_lanes(regfile_pkg::op_size_e size);
      case (size)
         regfile_pkg::size_lo8: return 4'b0001;
         regfile_pkg::size_hi8: return 4'b0010;
         regfile_pkg::size_16:  return 4'b0011;
         default:               return 4'b1111;
      endcase
   endfunction

   function automatic regfile_pkg::gpr_data_t read_gpr(regfile_pkg::gpr_data_t word,
                                                      regfile_pkg::op_size_e size);
      case (size)
         regfile_pkg::size_lo8: return word & 32'h0000_00ff;
         regfile_pkg::size_hi8: return (word >> 8) & 32'h0000_00ff;
         regfile_pkg::size_16:  return word & 32'h0000_ffff;
         default:               return word;
      endcase
   endfunction

   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      if (actual !== expected) begin
         $display("FAILED %s: expected %h, actual %h", name, expected, actual);
         $display("SOME TESTS FAILED");
         $fatal(1, "Mismatch in test %s", name);
      end
   endtask

   task automatic write_port(input int p, input regfile_pkg::reg_id_t id,
                             input regfile_pkg::op_size_e size,
                             input regfile_pkg::gpr_data_t data, input logic en);
      gpr_wr[p] <= '{we: en, id: id, size: size, data: data};
   endtask

   task automatic read_random();
      for (int i = 0; i < regfile_pkg::num_gpr_rd; i++) begin
         gpr_rd[i] <= '{id: regfile_pkg::reg_id_t'($random(seed)),
                        size: regfile_pkg::op_size_e'($random(seed) & 3)};
      end
   endtask

   task automatic stop_writes();
      for (int p = 0; p < regfile_pkg::num_gpr_wr; p++) begin
         gpr_wr[p].we <= 1'b0;
      end
      seg_we    <= 1'b0;
      mm_we     <= 1'b0;
      ld_cs     <= 1'b0;
      ld_eip    <= 1'b0;
      ld_eflags <= 1'b0;
   endtask

   // Model update, lowest port claims each lane first
   always @(posedge clk) begin : model_update
      regfile_pkg::lane_en_t claimed [regfile_pkg::num_regs];
      regfile_pkg::lane_en_t lanes;
      if (!rst_n) begin
         for (int r = 0; r < regfile_pkg::num_regs; r++) begin
            model_gpr[r] = '0;
            model_seg[r] = '0;
            model_mm[r]  = '0;
         end
         model_cs     = '0;
         model_eip    = '0;
         model_eflags = '0;
      end else begin
         for (int r = 0; r < regfile_pkg::num_regs; r++) begin
            claimed[r] = '0;
         end
         for (int p = 0; p < regfile_pkg::num_gpr_wr; p++) begin
            if (gpr_wr[p].we) begin
               lanes = size_lanes(gpr_wr[p].size) & ~claimed[gpr_wr[p].id];
               for (int l = 0; l < regfile_pkg::num_lanes; l++) begin
                  if (lanes[l]) begin
                     model_gpr[gpr_wr[p].id][l*8 +: 8] = gpr_wr[p].data[l*8 +: 8];
                  end
               end
               claimed[gpr_wr[p].id] = claimed[gpr_wr[p].id] | lanes;
            end
         end
         if (seg_we) model_seg[seg_wr_id] = seg_din;
         if (mm_we) model_mm[mm_wr_id] = mm_din;
         if (ld_cs) model_cs = cs_din;
         if (ld_eip) model_eip = eip_din;
         if (ld_eflags) model_eflags = eflags_din;
      end
   end

   // Outputs are settled by the falling edge
   always @(negedge clk) begin
      if (rst_n) begin
         for (int i = 0; i < regfile_pkg::num_gpr_rd; i++) begin
            check_value(test_name, read_gpr(model_gpr[gpr_rd[i].id], gpr_rd[i].size),
                        gpr_dout[i]);
         end
         check_value(test_name, model_seg[seg_rd_id1], seg_dout1);
         check_value(test_name, model_seg[seg_rd_id2], seg_dout2);
         check_value(test_name, model_mm[mm_rd_id1], mm_dout1);
         check_value(test_name, model_mm[mm_rd_id2], mm_dout2);
         check_value(test_name, model_cs, cs_dout);
         check_value(test_name, model_eip, eip_dout);
         check_value(test_name, model_eflags, eflags_dout);
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= max_cycles) begin
         $display("Simulation timed out after %0d cycles", cycles);
         $display("SOME TESTS FAILED");
         $fatal(1, "Timeout");
      end
   end

   initial begin : stimulus
      regfile_pkg::reg_id_t base_id;
      seed  = 32'h1f18;
      rst_n = 1'b0;
      for (int p = 0; p < regfile_pkg::num_gpr_wr; p++) gpr_wr[p] = '0;
      for (int i = 0; i < regfile_pkg::num_gpr_rd; i++) gpr_rd[i] = '0;
      {seg_wr_id, seg_rd_id1, seg_rd_id2, seg_we, seg_din} = '0;
      {mm_wr_id, mm_rd_id1, mm_rd_id2, mm_we, mm_din} = '0;
      {cs_din, eip_din, eflags_din, ld_cs, ld_eip, ld_eflags} = '0;
      repeat (16) @(posedge clk);
      rst_n <= 1'b1;

      // Everything reads zero out of reset
      for (int r = 0; r < regfile_pkg::num_regs; r++) begin
         @(posedge clk);
         for (int i = 0; i < regfile_pkg::num_gpr_rd; i++) begin
            gpr_rd[i] <= '{id: regfile_pkg::reg_id_t'(r + i), size: regfile_pkg::size_32};
         end
         seg_rd_id1 <= regfile_pkg::reg_id_t'(r);
         seg_rd_id2 <= regfile_pkg::reg_id_t'(r + 1);
         mm_rd_id1  <= regfile_pkg::reg_id_t'(r + 2);
         mm_rd_id2  <= regfile_pkg::reg_id_t'(r);
         @(negedge clk);
         for (int i = 0; i < regfile_pkg::num_gpr_rd; i++) check_value("reset", 0, gpr_dout[i]);
         check_value("reset", 0, seg_dout1);
         check_value("reset", 0, seg_dout2);
         check_value("reset", 0, mm_dout1);
         check_value("reset", 0, mm_dout2);
         check_value("reset", 0, cs_dout);
         check_value("reset", 0, eip_dout);
         check_value("reset", 0, eflags_dout);
      end

      test_name = "write32";
      for (int k = 0; k < 3; k++) begin
         @(posedge clk);
         for (int p = 0; p < regfile_pkg::num_gpr_wr; p++) begin
            write_port(p, regfile_pkg::reg_id_t'(3 * k + p), regfile_pkg::size_32,
                       $random(seed), 1'b1);
         end
      end
      @(posedge clk);
      stop_writes();
      for (int r = 0; r < regfile_pkg::num_regs; r++) begin
         @(posedge clk);
         for (int i = 0; i < regfile_pkg::num_gpr_rd; i++) begin
            gpr_rd[i] <= '{id: regfile_pkg::reg_id_t'(r + 2 * i), size: regfile_pkg::size_32};
         end
      end

      // Partial writes, one read port per operand size
      test_name = "sized";
      for (int c = 0; c < 48; c++) begin
         @(posedge clk);
         write_port(c % 3, regfile_pkg::reg_id_t'($random(seed)),
                    regfile_pkg::op_size_e'(c % 3), $random(seed), 1'b1);
         write_port((c + 1) % 3, '0, regfile_pkg::size_32, '0, 1'b0);
         write_port((c + 2) % 3, '0, regfile_pkg::size_32, '0, 1'b0);
         for (int i = 0; i < regfile_pkg::num_gpr_rd; i++) begin
            gpr_rd[i] <= '{id: regfile_pkg::reg_id_t'($random(seed)),
                           size: regfile_pkg::op_size_e'(i)};
         end
      end

      // Every fourth cycle all ports hit one register
      test_name = "concurrent";
      for (int c = 0; c < rand_cycles; c++) begin
         @(posedge clk);
         base_id = regfile_pkg::reg_id_t'($random(seed));
         for (int p = 0; p < regfile_pkg::num_gpr_wr; p++) begin
            write_port(p, (c % 4 == 0) ? base_id : regfile_pkg::reg_id_t'($random(seed)),
                       regfile_pkg::op_size_e'($random(seed) & 3), $random(seed),
                       (c % 4 == 0) || ($random(seed) & 1));
         end
         read_random();
      end
      @(posedge clk);
      stop_writes();

      // Port 1 reads the entry being written
      test_name = "seg_mm";
      for (int c = 0; c < rand_cycles; c++) begin
         @(posedge clk);
         base_id = regfile_pkg::reg_id_t'($random(seed));
         seg_we     <= $random(seed);
         seg_wr_id  <= base_id;
         seg_din    <= $random(seed);
         seg_rd_id1 <= base_id;
         seg_rd_id2 <= $random(seed);
         base_id = regfile_pkg::reg_id_t'($random(seed));
         mm_we      <= $random(seed);
         mm_wr_id   <= base_id;
         mm_din     <= {$random(seed), $random(seed)};
         mm_rd_id1  <= base_id;
         mm_rd_id2  <= $random(seed);
      end
      @(posedge clk);
      stop_writes();

      test_name = "arch";
      for (int c = 0; c < rand_cycles; c++) begin
         @(posedge clk);
         ld_cs      <= $random(seed);
         ld_eip     <= $random(seed);
         ld_eflags  <= $random(seed);
         cs_din     <= $random(seed);
         eip_din    <= $random(seed);
         eflags_din <= $random(seed);
      end
      @(posedge clk);
      stop_writes();
      repeat (2) @(posedge clk);
      @(negedge clk);
      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

/* project.f */
regfile_pkg.sv
gpr_write_arbiter.sv
gpr_read_port.sv
gpr_array.sv
dual_read_regfile.sv
arch_state_regs.sv
register_file.sv
register_file_tb.sv

/* Bender.yml */
package:
  name: register_file

sources:
  - regfile_pkg.sv
  - gpr_write_arbiter.sv
  - gpr_read_port.sv
  - gpr_array.sv
  - dual_read_regfile.sv
  - arch_state_regs.sv
  - register_file.sv
  - target: simulation
    files:
      - register_file_tb.sv
